/* hangman.f */
+incdir+testbench
source/hangmanPkg.sv
source/gameIf.sv
source/wordStore.sv
source/guessChecker.sv
source/gameControl.sv
source/hostDisplay.sv
source/hangmanTop.sv
testbench/hangmanTb.sv

/* source/gameControl.sv */
//////////////////////////////
// Hangman game FSM
// Tracks revealed letters, mistakes and the outcome
//////////////////////////////

`timescale 1ns/1ps

module gameControl (
    input logic clk,
    input logic nRst,
    input logic newGame,
    gameIf.control bus
);
    import hangmanPkg::*;

    logic [$clog2(maxMistakes+1)-1:0] mistakes;
    logic [$clog2(maxMistakes+1)-1:0] nextMistakes;
    logic [wordLetters-1:0] nextRevealed;
    gameStateT nextState;
    logic nextStart;
    logic nextMiss;

    always_comb begin
        nextState = bus.state;
        nextRevealed = bus.revealed;
        nextMistakes = mistakes;
        nextStart = 1'b0;
        nextMiss = 1'b0;

        // A new game wins over a guess arriving in the same cycle
        if (newGame) begin
            nextState = play;
            nextRevealed = '0;
            nextMistakes = '0;
            nextStart = 1'b1;
        end else if (bus.guess && bus.state == play) begin
            nextRevealed = bus.revealed | bus.hitMask;
            if (bus.miss) begin
                nextMistakes = mistakes + 1'b1;
                nextMiss = 1'b1;
            end

            // The outcome is decided on the same edge as the guess
            if (&nextRevealed) begin
                nextState = won;
            end else if (nextMistakes == maxMistakes) begin
                nextState = lost;
            end
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            bus.state <= idle;
            bus.revealed <= '0;
            mistakes <= '0;
            bus.startPulse <= 1'b0;
            bus.missPulse <= 1'b0;
        end else begin
            bus.state <= nextState;
            bus.revealed <= nextRevealed;
            mistakes <= nextMistakes;
            bus.startPulse <= nextStart;
            bus.missPulse <= nextMiss;
        end
    end

    // Only read together with missPulse, so every guess may load it
    always_ff @(posedge clk) begin
        if (bus.guess) begin
            bus.missLetter <= bus.letter;
        end
    end

endmodule

/* source/gameIf.sv */
//////////////////////////////
// Internal hangman game bus
// Guess, word, reveal and state signals
//////////////////////////////

`timescale 1ns/1ps

interface gameIf;
    import hangmanPkg::*;

    // Guess input, straight from the top level ports
    charT letter;
    logic guess;

    wordT word;

    // Combinational compare results for the current letter
    logic [wordLetters-1:0] hitMask;
    logic miss;

    // Registered game status
    logic [wordLetters-1:0] revealed;
    gameStateT state;
    logic startPulse;
    logic missPulse;
    charT missLetter;

    modport store (output word);
    modport check (input letter, word, revealed, output hitMask, miss);
    modport control (input guess, letter, hitMask, miss,
                     output revealed, state, startPulse, missPulse, missLetter);
    modport display (input word, revealed, state, startPulse, missPulse, missLetter);

endinterface

/* source/guessChecker.sv */
//////////////////////////////
// Guess checker
// Compares a letter against every word position
//////////////////////////////

`timescale 1ns/1ps

module guessChecker (
    gameIf.check bus
);
    import hangmanPkg::*;

    logic [wordLetters-1:0] match;

    // Bit i of each mask refers to byte i of the word, so bit 0 is the
    // rightmost letter
    always_comb begin
        for (int i = 0; i < wordLetters; i++) begin
            match[i] = (bus.word[8*i +: 8] == bus.letter);
        end
    end

    // Only positions still hidden count as new hits
    assign bus.hitMask = match & ~bus.revealed;

    // A letter that appears nowhere in the word is a mistake, even if it
    // was guessed before
    assign bus.miss = ~|match;

endmodule

/* source/hangmanPkg.sv */
//////////////////////////////
// Hangman shared definitions
// Game constants, character and row types, game states
//////////////////////////////

package hangmanPkg;

    // Letters in every secret word
    localparam int wordLetters = 5;

    // The sixth wrong guess ends the game
    localparam int maxMistakes = 6;

    // Characters on one line of the 16x2 display
    localparam int rowChars = 16;

    // Entries in the word ROM
    localparam int numWords = 8;

    // One ASCII byte
    typedef logic [7:0] charT;

    // Leftmost letter sits in the high byte
    typedef logic [wordLetters*8-1:0] wordT;

    // Leftmost character sits in the high byte
    typedef logic [rowChars*8-1:0] rowT;

    typedef enum logic [1:0] {
        idle,
        play,
        won,
        lost
    } gameStateT;

    // Marks a hidden letter or an empty wrong-letter slot
    localparam charT blankChar = 8'h5F;

    // Fills the unused display columns
    localparam charT padChar = 8'h20;

endpackage

/* source/hangmanTop.sv */
//////////////////////////////
// Hangman game top level
// Word store, checker, FSM and display
//////////////////////////////

`timescale 1ns/1ps

module hangmanTop (
    input logic clk,
    input logic nRst,
    // Starts a game with the word picked by wordIndex
    input logic newGame,
    input logic [$clog2(hangmanPkg::numWords)-1:0] wordIndex,
    // One-cycle strobe, letter is valid while it is high
    input logic guess,
    input hangmanPkg::charT letter,
    output hangmanPkg::rowT top,
    output hangmanPkg::rowT bottom
);

    gameIf bus ();

    // The guess enters the internal bus unregistered
    assign bus.letter = letter;
    assign bus.guess = guess;

    wordStore uWordStore (
        .clk(clk),
        .nRst(nRst),
        .newGame(newGame),
        .wordIndex(wordIndex),
        .bus(bus.store)
    );

    // Purely combinational, feeds hitMask and miss to the FSM
    guessChecker uGuessChecker (
        .bus(bus.check)
    );

    gameControl uGameControl (
        .clk(clk),
        .nRst(nRst),
        .newGame(newGame),
        .bus(bus.control)
    );

    // Rows follow a guess two rising edges after it is sampled
    hostDisplay uHostDisplay (
        .clk(clk),
        .nRst(nRst),
        .bus(bus.display),
        .top(top),
        .bottom(bottom)
    );

endmodule

/* source/hostDisplay.sv */
//////////////////////////////
// Hangman display rows
// Builds the two 16-character ASCII lines
//////////////////////////////

`timescale 1ns/1ps

module hostDisplay (
    input logic clk,
    input logic nRst,
    gameIf.display bus,
    output hangmanPkg::rowT top,
    output hangmanPkg::rowT bottom
);
    import hangmanPkg::*;

    // Six wrong-letter slots, newest in the high byte
    logic [maxMistakes*8-1:0] wrongLetters;
    logic [maxMistakes*8-1:0] nextWrong;
    wordT shownWord;
    rowT nextTop;
    rowT nextBottom;

    // The rows are built from the slot contents of this same edge, so a
    // miss shows up together with the rest of its guess
    always_comb begin
        if (bus.startPulse) begin
            nextWrong = {maxMistakes{blankChar}};
        end else if (bus.missPulse) begin
            nextWrong = {bus.missLetter, wrongLetters[maxMistakes*8-1:8]};
        end else begin
            nextWrong = wrongLetters;
        end
    end

    always_ff @(posedge clk) begin
        wrongLetters <= nextWrong;
    end

    // Hidden positions show as underscores
    always_comb begin
        for (int i = 0; i < wordLetters; i++) begin
            shownWord[8*i +: 8] = bus.revealed[i] ? bus.word[8*i +: 8] : blankChar;
        end
    end

    always_comb begin
        case (bus.state)
            play: begin
                nextTop = {{5{padChar}}, shownWord, {(rowChars-5-wordLetters){padChar}}};
                nextBottom = {{5{padChar}}, nextWrong,
                              {(rowChars-5-maxMistakes){padChar}}};
            end
            won: begin
                nextTop = {{6{padChar}}, "Win", {7{padChar}}};
                nextBottom = {{5{padChar}}, bus.word, {(rowChars-5-wordLetters){padChar}}};
            end
            lost: begin
                nextTop = {{6{padChar}}, "Lose", {6{padChar}}};
                nextBottom = {{5{padChar}}, bus.word, {(rowChars-5-wordLetters){padChar}}};
            end
            default: begin
                // Before the first game the rows keep their reset value
                nextTop = top;
                nextBottom = bottom;
            end
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            top <= '0;
            bottom <= '0;
        end else begin
            top <= nextTop;
            bottom <= nextBottom;
        end
    end

endmodule

/* source/wordStore.sv */
//////////////////////////////
// Secret word store
// Word ROM and the current-word register
//////////////////////////////

`timescale 1ns/1ps

module wordStore (
    input logic clk,
    input logic nRst,
    input logic newGame,
    input logic [$clog2(hangmanPkg::numWords)-1:0] wordIndex,
    gameIf.store bus
);
    import hangmanPkg::*;

    wordT romWord;

    // Eight words, several with repeated letters so one guess can
    // reveal more than one position
    always_comb begin
        case (wordIndex)
            3'd0: romWord = "APPLE";
            3'd1: romWord = "LEVEL";
            3'd2: romWord = "GRASS";
            3'd3: romWord = "HELLO";
            3'd4: romWord = "SHEEP";
            3'd5: romWord = "TOOTH";
            3'd6: romWord = "CRANE";
            default: romWord = "PIZZA";
        endcase
    end

    // The word is latched once per game and held until the next newGame
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            bus.word <= {wordLetters{blankChar}};
        end else if (newGame) begin
            bus.word <= romWord;
        end
    end

endmodule

/* testbench/hangmanModel.svh */
//////////////////////////////
// Hangman reference model
// Game rules and expected display rows
//////////////////////////////

`ifndef hangmanModelSvh
`define hangmanModelSvh

// Same word list as the game ROM, leftmost letter first
wordT modelWords [numWords] = '{"APPLE", "LEVEL", "GRASS", "HELLO",
                                "SHEEP", "TOOTH", "CRANE", "PIZZA"};

// Position 0 is the leftmost letter and slot 0 the leftmost wrong letter
charT modelWord [wordLetters];
bit modelShown [wordLetters];
charT modelWrong [maxMistakes];
int modelMistakes = 0;
gameStateT modelState = idle;

function automatic void startModel(int idx);
    for (int k = 0; k < wordLetters; k++) begin
        modelWord[k] = modelWords[idx][8*(wordLetters-1-k) +: 8];
        modelShown[k] = 1'b0;
    end
    for (int k = 0; k < maxMistakes; k++) begin
        modelWrong[k] = blankChar;
    end
    modelMistakes = 0;
    modelState = play;
endfunction

function automatic void guessModel(charT ch);
    bit found;
    bit allShown;
    if (modelState != play) begin
        return;
    end
    found = 1'b0;
    allShown = 1'b1;
    for (int k = 0; k < wordLetters; k++) begin
        if (modelWord[k] == ch) begin
            found = 1'b1;
            modelShown[k] = 1'b1;
        end
        allShown = allShown & modelShown[k];
    end
    // A wrong letter pushes the older ones one slot to the right
    if (!found) begin
        for (int k = maxMistakes - 1; k > 0; k--) begin
            modelWrong[k] = modelWrong[k-1];
        end
        modelWrong[0] = ch;
        modelMistakes++;
    end
    if (allShown) begin
        modelState = won;
    end else if (modelMistakes == maxMistakes) begin
        modelState = lost;
    end
endfunction

// Column 0 is the leftmost character of the row
function automatic rowT placeChar(rowT row, int col, charT ch);
    row[8*(rowChars-1-col) +: 8] = ch;
    return row;
endfunction

function automatic rowT expectedTop();
    rowT row;
    string msg;
    if (modelState == idle) begin
        return '0;
    end
    row = {rowChars{padChar}};
    if (modelState == play) begin
        for (int k = 0; k < wordLetters; k++) begin
            row = placeChar(row, 5 + k, modelShown[k] ? modelWord[k] : blankChar);
        end
    end else begin
        if (modelState == won) begin
            msg = "Win";
        end else begin
            msg = "Lose";
        end
        for (int k = 0; k < msg.len(); k++) begin
            row = placeChar(row, 6 + k, msg[k]);
        end
    end
    return row;
endfunction

function automatic rowT expectedBottom();
    rowT row;
    if (modelState == idle) begin
        return '0;
    end
    row = {rowChars{padChar}};
    if (modelState == play) begin
        for (int k = 0; k < maxMistakes; k++) begin
            row = placeChar(row, 5 + k, modelWrong[k]);
        end
    end else begin
        // The finished game uncovers the whole word
        for (int k = 0; k < wordLetters; k++) begin
            row = placeChar(row, 5 + k, modelWord[k]);
        end
    end
    return row;
endfunction

`endif

/* testbench/hangmanTb.sv */
//////////////////////////////
// Hangman testbench
// Random games checked against a reference model
//////////////////////////////

`timescale 1ns/1ps

module hangmanTb;
    import hangmanPkg::*;

    localparam int period = 100;
    localparam int resetCycles = 16;
    localparam int numGames = 24;
    // Longest game: start, about twenty guesses in bursts, two late guesses
    localparam int maxGameCycles = 150;
    localparam int marginCycles = 50;
    localparam int timeoutNs = (resetCycles + numGames * maxGameCycles + marginCycles) * period;

    logic clk;
    logic nRst;
    logic newGame;
    logic [$clog2(numWords)-1:0] wordIndex;
    logic guess;
    charT letter;
    rowT top;
    rowT bottom;

    int errors = 0;
    int checks = 0;
    integer seed = 32'h7747;

    `include "hangmanModel.svh"

    hangmanTop dut (
        .clk(clk),
        .nRst(nRst),
        .newGame(newGame),
        .wordIndex(wordIndex),
        .guess(guess),
        .letter(letter),
        .top(top),
        .bottom(bottom)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    function automatic int randomBelow(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Mostly letters of the current word when hitPercent is high
    function automatic charT pickLetter(int hitPercent);
        if (randomBelow(100) < hitPercent) begin
            return modelWord[randomBelow(wordLetters)];
        end
        return charT'(8'h41 + randomBelow(26));
    endfunction

    task automatic checkValue(string name, rowT expected, rowT actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h \"%s\", actual %h \"%s\"",
                     name, expected, expected, actual, actual);
        end
    endtask

    task automatic checkRows(string name);
        checkValue({name, " top"}, expectedTop(), top);
        checkValue({name, " bottom"}, expectedBottom(), bottom);
    endtask

    // A guess in the same cycle as newGame must have no effect
    task automatic startGame(int idx, bit withGuess, string name);
        @(negedge clk);
        newGame = 1'b1;
        wordIndex = idx;
        guess = withGuess;
        letter = pickLetter(0);
        @(negedge clk);
        newGame = 1'b0;
        guess = 1'b0;
        startModel(idx);
        @(negedge clk);
        checkRows(name);
    endtask

    // Guesses go out on consecutive cycles, rows are checked after the last
    task automatic sendGuesses(int count, int hitPercent, string name);
        charT ch;
        for (int k = 0; k < count; k++) begin
            @(negedge clk);
            ch = pickLetter(hitPercent);
            guess = 1'b1;
            letter = ch;
            guessModel(ch);
        end
        @(negedge clk);
        guess = 1'b0;
        @(negedge clk);
        checkRows(name);
    endtask

    initial begin
        int hitPercent;
        int step;
        string name;
        bit withGuess;
        nRst = 1'b0;
        newGame = 1'b0;
        wordIndex = '0;
        guess = 1'b0;
        letter = '0;
        repeat (resetCycles) @(negedge clk);
        nRst = 1'b1;
        @(negedge clk);
        checkRows("after reset");

        for (int game = 0; game < numGames; game++) begin
            // Alternate between games aimed at a win and games aimed at a loss
            hitPercent = (game % 2 == 0) ? 75 : 20;
            withGuess = (game % 3 == 0);
            // The guess on the newGame edge then meets a board that is in play
            if (withGuess) begin
                startGame(randomBelow(numWords), 1'b0,
                          $sformatf("game %0d first board", game));
            end
            startGame(randomBelow(numWords), withGuess, $sformatf("game %0d start", game));
            step = 0;
            while (modelState == play && step < 20) begin
                name = $sformatf("game %0d guess %0d", game, step);
                if (randomBelow(4) == 0) begin
                    sendGuesses(3, hitPercent, {name, " burst"});
                    step += 3;
                end else begin
                    sendGuesses(1, hitPercent, name);
                    step++;
                end
            end
            // Late guesses leave a finished board alone
            sendGuesses(2, 50, $sformatf("game %0d after end", game));
        end

        $display("Closing report: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("Timeout: the games did not finish within %0d ns", timeoutNs);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
